//--- sources.f
hdl/dbusPkg.sv
hdl/dbusIf.sv
hdl/dbusMaster.sv
hdl/dbusArbiter.sv
hdl/dbusRam.sv
hdl/dbusSystem.sv
tests/dbusSystem_checker.sv
tests/dbusSystem_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dbusSystem_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Done: errors found" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/dbusSystem_tb.sv
module dbusSystem_tb;
    import dbusPkg::*;

    localparam int WAIT_STATES = 2;
    localparam int TIMEOUT     = 200;
    localparam busMode_t LOAD_MODES [5] = '{MODE_B, MODE_BU, MODE_H, MODE_HU, MODE_W};
    localparam busMode_t STORE_MODES [3] = '{MODE_B, MODE_H, MODE_W};

    logic     clk;
    logic     arstN;
    logic     cpu0Re, cpu0We, cpu1Re, cpu1We;
    busMode_t cpu0Mode, cpu1Mode;
    cpuAddr_t cpu0Addr, cpu1Addr;
    busData_t cpu0Wd, cpu1Wd, cpu0Rd, cpu1Rd;
    logic     cpu0Busy, cpu1Busy, cpu0Done, cpu1Done, cpu0Mis, cpu1Mis;

    // Reference memory with one entry per byte
    logic [7:0] model [0:255];
    int errors;
    int checks;
    int passedTests;
    int failedTests;

    dbusSystem #(.WAIT_STATES(WAIT_STATES)) dut_i (
        .i_Clk (clk), .i_arstN (arstN),
        .i_cpu0Re (cpu0Re), .i_cpu0We (cpu0We), .i_cpu0Mode (cpu0Mode),
        .i_cpu0Addr (cpu0Addr), .i_cpu0Wd (cpu0Wd), .o_cpu0Rd (cpu0Rd),
        .o_cpu0Busy (cpu0Busy), .o_cpu0Done (cpu0Done), .o_cpu0Misaligned (cpu0Mis),
        .i_cpu1Re (cpu1Re), .i_cpu1We (cpu1We), .i_cpu1Mode (cpu1Mode),
        .i_cpu1Addr (cpu1Addr), .i_cpu1Wd (cpu1Wd), .o_cpu1Rd (cpu1Rd),
        .o_cpu1Busy (cpu1Busy), .o_cpu1Done (cpu1Done), .o_cpu1Misaligned (cpu1Mis)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic busyOf(input int port);
        return (port == 0) ? cpu0Busy : cpu1Busy;
    endfunction

    function automatic logic doneOf(input int port);
        return (port == 0) ? cpu0Done : cpu1Done;
    endfunction

    function automatic logic misOf(input int port);
        return (port == 0) ? cpu0Mis : cpu1Mis;
    endfunction

    function automatic busData_t rdOf(input int port);
        return (port == 0) ? cpu0Rd : cpu1Rd;
    endfunction

    function automatic string sigName(input int port, input string suffix);
        return $sformatf("o_cpu%0d%s", port, suffix);
    endfunction

    function automatic int accessBytes(input busMode_t mode);
        int n;
        case (mode)
            MODE_B, MODE_BU: n = 1;
            MODE_H, MODE_HU: n = 2;
            default:         n = 4;
        endcase
        return n;
    endfunction

    function automatic logic isMisaligned(input busMode_t mode, input cpuAddr_t addr);
        logic mis;
        case (mode)
            MODE_H, MODE_HU: mis = addr[0];
            MODE_W:          mis = (addr[1:0] != 2'b00);
            default:         mis = 1'b0;
        endcase
        return mis;
    endfunction

    // Little endian with the lowest byte at the lowest address
    function automatic void storeModel(input busMode_t mode, input cpuAddr_t addr,
                                       input busData_t wd);
        int base;
        base = int'(addr[7:0]);
        for (int k = 0; k < accessBytes(mode); k++) begin
            model[base + k] = wd[8*k +: 8];
        end
    endfunction

    function automatic busData_t loadModel(input busMode_t mode, input cpuAddr_t addr);
        busData_t raw;
        busData_t value;
        int base;
        base = int'(addr[7:0]);
        raw  = '0;
        for (int k = 0; k < accessBytes(mode); k++) begin
            raw[8*k +: 8] = model[base + k];
        end
        case (mode)
            MODE_B:  value = {{24{raw[7]}}, raw[7:0]};
            MODE_H:  value = {{16{raw[15]}}, raw[15:0]};
            default: value = raw;
        endcase
        return value;
    endfunction

    // Port 0 owns words 0 to 31 and port 1 owns words 32 to 63
    function automatic cpuAddr_t randAddr(input int port, input busMode_t mode);
        int word;
        int offset;
        word = port * 32 + int'($urandom % 32);
        case (mode)
            MODE_B, MODE_BU: offset = int'($urandom % 4);
            MODE_H, MODE_HU: offset = int'($urandom % 2) * 2;
            default:         offset = 0;
        endcase
        return cpuAddr_t'(word * 4 + offset);
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic checkData(input string name, input busData_t got, input busData_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkLatency(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAIL %s latency: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic driveStrobe(input int port, input logic re, input logic we,
                               input busMode_t mode, input cpuAddr_t addr, input busData_t wd);
        if (port == 0) begin
            cpu0Re   = re;
            cpu0We   = we;
            cpu0Mode = mode;
            cpu0Addr = addr;
            cpu0Wd   = wd;
        end else begin
            cpu1Re   = re;
            cpu1We   = we;
            cpu1Mode = mode;
            cpu1Addr = addr;
            cpu1Wd   = wd;
        end
    endtask

    task automatic clearStrobe(input int port);
        driveStrobe(port, 1'b0, 1'b0, MODE_B, '0, '0);
    endtask

    task automatic stallAbort(input int port);
        $display("Timeout: port %0d stalled, no done within %0d cycles", port, TIMEOUT);
        $display("Done: errors found");
        $finish;
    endtask

    // One core access with optional strobes that arrive while busy
    task automatic doAccess(input int port, input logic re, input logic we,
                            input busMode_t mode, input cpuAddr_t addr, input busData_t wd,
                            input logic ghost, output busData_t rd, output int cycles);
        rd = '0;
        driveStrobe(port, re, we, mode, addr, wd);
        tick();
        cycles = 1;
        clearStrobe(port);
        checkFlag(sigName(port, "Done"), doneOf(port), 1'b0);
        if (isMisaligned(mode, addr)) begin
            checkFlag(sigName(port, "Misaligned"), misOf(port), 1'b1);
            checkFlag(sigName(port, "Busy"), busyOf(port), 1'b0);
            tick();
            checkFlag(sigName(port, "Misaligned"), misOf(port), 1'b0);
            checkFlag(sigName(port, "Done"), doneOf(port), 1'b0);
            tick();
            checkFlag(sigName(port, "Done"), doneOf(port), 1'b0);
        end else begin
            checkFlag(sigName(port, "Busy"), busyOf(port), 1'b1);
            while (!doneOf(port) && cycles < TIMEOUT) begin
                if (ghost && busyOf(port) && ($urandom % 4 == 0)) begin
                    driveStrobe(port, 1'b0, 1'b1, MODE_W, randAddr(port, MODE_W), $urandom);
                end else begin
                    clearStrobe(port);
                end
                tick();
                cycles++;
            end
            clearStrobe(port);
            if (!doneOf(port)) begin
                stallAbort(port);
            end else begin
                rd = rdOf(port);
                if (!re) begin
                    storeModel(mode, addr, wd);
                end
            end
        end
    endtask

    task automatic fillWords(input int port);
        busData_t rd;
        int cycles;
        for (int w = 0; w < 32; w++) begin
            doAccess(port, 1'b0, 1'b1, MODE_W, cpuAddr_t'((port * 32 + w) * 4), $urandom,
                     1'b0, rd, cycles);
        end
    endtask

    task automatic trafficRun(input int port, input int ops);
        busMode_t mode;
        cpuAddr_t addr;
        busData_t rd;
        int kind;
        int cycles;
        logic re;
        logic we;
        for (int i = 0; i < ops; i++) begin
            kind = int'($urandom % 8);
            // Both strobes together count as a read
            re   = (kind >= 4);
            we   = (kind < 4) || (kind == 7);
            mode = re ? LOAD_MODES[$urandom % 5] : STORE_MODES[$urandom % 3];
            addr = randAddr(port, mode);
            doAccess(port, re, we, mode, addr, $urandom, 1'b1, rd, cycles);
            if (re) begin
                checkData(sigName(port, "Rd"), rd, loadModel(mode, addr));
            end
            if ($urandom % 4 == 0) begin
                tick();
            end
        end
    endtask

    task automatic endTest(input string name, input int errBefore);
        if (errors == errBefore) begin
            passedTests++;
            $display("Test %s: pass", name);
        end else begin
            failedTests++;
            $display("Test %s: %0d errors", name, errors - errBefore);
        end
    endtask

    initial begin
        busData_t rd;
        busData_t wd;
        busMode_t mode;
        cpuAddr_t addr;
        int cycles;
        int errBefore;
        int port;
        logic re;

        void'($urandom(65));
        errors      = 0;
        checks      = 0;
        passedTests = 0;
        failedTests = 0;
        arstN       = 1'b0;
        clearStrobe(0);
        clearStrobe(1);
        repeat (16) @(posedge clk);
        #2;
        arstN = 1'b1;
        tick();

        errBefore = errors;
        for (int p = 0; p < 2; p++) begin
            checkFlag(sigName(p, "Busy"), busyOf(p), 1'b0);
            checkFlag(sigName(p, "Done"), doneOf(p), 1'b0);
            checkFlag(sigName(p, "Misaligned"), misOf(p), 1'b0);
        end
        endTest("reset", errBefore);

        errBefore = errors;
        for (int i = 0; i < 4; i++) begin
            addr = randAddr(0, MODE_W);
            wd   = $urandom;
            doAccess(0, 1'b0, 1'b1, MODE_W, addr, wd, 1'b0, rd, cycles);
            checkLatency(sigName(0, "Done"), cycles, WAIT_STATES + 4);
            doAccess(0, 1'b1, 1'b0, MODE_W, addr, '0, 1'b0, rd, cycles);
            checkLatency(sigName(0, "Done"), cycles, WAIT_STATES + 4);
            checkData(sigName(0, "Rd"), rd, wd);
        end
        endTest("word round trip", errBefore);

        errBefore = errors;
        fork
            fillWords(0);
            fillWords(1);
        join
        for (int i = 0; i < 40; i++) begin
            port = i % 2;
            mode = STORE_MODES[$urandom % 2];
            addr = randAddr(port, mode);
            doAccess(port, 1'b0, 1'b1, mode, addr, $urandom, 1'b0, rd, cycles);
            addr = {addr[31:2], 2'b00};
            doAccess(port, 1'b1, 1'b0, MODE_W, addr, '0, 1'b0, rd, cycles);
            checkData(sigName(port, "Rd"), rd, loadModel(MODE_W, addr));
            mode = LOAD_MODES[$urandom % 4];
            addr = randAddr(port, mode);
            doAccess(port, 1'b1, 1'b0, mode, addr, '0, 1'b0, rd, cycles);
            checkData(sigName(port, "Rd"), rd, loadModel(mode, addr));
        end
        endTest("sub-word lanes", errBefore);

        errBefore = errors;
        for (int i = 0; i < 12; i++) begin
            port = i % 2;
            re   = 1'($urandom % 2);
            if ($urandom % 2) begin
                mode = MODE_W;
                addr = randAddr(port, MODE_W) + cpuAddr_t'(1 + $urandom % 3);
            end else begin
                mode = ($urandom % 2) ? MODE_H : MODE_HU;
                addr = randAddr(port, MODE_H) | 32'd1;
            end
            doAccess(port, re, ~re, mode, addr, $urandom, 1'b0, rd, cycles);
            addr = {addr[31:2], 2'b00};
            doAccess(port, 1'b1, 1'b0, MODE_W, addr, '0, 1'b0, rd, cycles);
            checkData(sigName(port, "Rd"), rd, loadModel(MODE_W, addr));
        end
        endTest("misaligned", errBefore);

        errBefore = errors;
        fork
            trafficRun(0, 150);
            trafficRun(1, 150);
        join
        endTest("contention", errBefore);

        $display("Tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
                 passedTests, failedTests, checks, errors);
        if (errors == 0 && failedTests == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- tests/dbusSystem_checker.sv
module dbusSystem_checker (
    input logic i_Clk,
    input logic i_arstN,
    input logic i_req0,
    input logic i_req1,
    input logic i_gnt0,
    input logic i_gnt1,
    input logic i_ramRead,
    input logic i_ramWrite
);

    // Only one owner of the RAM link
    oneOwner: assert property (@(posedge i_Clk) disable iff (!i_arstN) !(i_gnt0 && i_gnt1))
        else $error("gnt high on both master links");

    gnt0WithReq: assert property (@(posedge i_Clk) disable iff (!i_arstN) i_gnt0 |-> i_req0)
        else $error("gnt on link 0 without req");

    gnt1WithReq: assert property (@(posedge i_Clk) disable iff (!i_arstN) i_gnt1 |-> i_req1)
        else $error("gnt on link 1 without req");

    // A transfer is a read or a write, never both
    oneStrobe: assert property (@(posedge i_Clk) disable iff (!i_arstN)
        !(i_ramRead && i_ramWrite))
        else $error("read and write together on the RAM link");

endmodule

bind dbusArbiter dbusSystem_checker checker_i (
    .i_Clk      (i_Clk),
    .i_arstN    (i_arstN),
    .i_req0     (m0.req),
    .i_req1     (m1.req),
    .i_gnt0     (m0.gnt),
    .i_gnt1     (m1.gnt),
    .i_ramRead  (ram.read),
    .i_ramWrite (ram.write)
);

//--- hdl/dbusSystem.sv
module dbusSystem #(
    parameter int WAIT_STATES = 2
) (
    input  logic               i_Clk,
    input  logic               i_arstN,

    // CPU0 load/store port
    input  logic               i_cpu0Re,
    input  logic               i_cpu0We,
    input  dbusPkg::busMode_t  i_cpu0Mode,
    input  dbusPkg::cpuAddr_t  i_cpu0Addr,
    input  dbusPkg::busData_t  i_cpu0Wd,
    output dbusPkg::busData_t  o_cpu0Rd,
    output logic               o_cpu0Busy,
    output logic               o_cpu0Done,
    output logic               o_cpu0Misaligned,

    // CPU1 load/store port
    input  logic               i_cpu1Re,
    input  logic               i_cpu1We,
    input  dbusPkg::busMode_t  i_cpu1Mode,
    input  dbusPkg::cpuAddr_t  i_cpu1Addr,
    input  dbusPkg::busData_t  i_cpu1Wd,
    output dbusPkg::busData_t  o_cpu1Rd,
    output logic               o_cpu1Busy,
    output logic               o_cpu1Done,
    output logic               o_cpu1Misaligned
);

    dbusIf cpu0Link ();
    dbusIf cpu1Link ();
    dbusIf ramLink ();

    dbusMaster cpu0Master_i (
        .i_Clk           (i_Clk),
        .i_arstN         (i_arstN),
        .i_cpuRe         (i_cpu0Re),
        .i_cpuWe         (i_cpu0We),
        .i_cpuMode       (i_cpu0Mode),
        .i_cpuAddr       (i_cpu0Addr),
        .i_cpuWd         (i_cpu0Wd),
        .o_cpuRd         (o_cpu0Rd),
        .o_cpuBusy       (o_cpu0Busy),
        .o_cpuDone       (o_cpu0Done),
        .o_cpuMisaligned (o_cpu0Misaligned),
        .bus             (cpu0Link.master)
    );

    dbusMaster cpu1Master_i (
        .i_Clk           (i_Clk),
        .i_arstN         (i_arstN),
        .i_cpuRe         (i_cpu1Re),
        .i_cpuWe         (i_cpu1We),
        .i_cpuMode       (i_cpu1Mode),
        .i_cpuAddr       (i_cpu1Addr),
        .i_cpuWd         (i_cpu1Wd),
        .o_cpuRd         (o_cpu1Rd),
        .o_cpuBusy       (o_cpu1Busy),
        .o_cpuDone       (o_cpu1Done),
        .o_cpuMisaligned (o_cpu1Misaligned),
        .bus             (cpu1Link.master)
    );

    dbusArbiter arbiter_i (
        .i_Clk   (i_Clk),
        .i_arstN (i_arstN),
        .m0      (cpu0Link.slave),
        .m1      (cpu1Link.slave),
        .ram     (ramLink.master)
    );

    dbusRam #(
        .WAIT_STATES (WAIT_STATES)
    ) ram_i (
        .i_Clk   (i_Clk),
        .i_arstN (i_arstN),
        .bus     (ramLink.slave)
    );

endmodule

//--- hdl/dbusRam.sv
module dbusRam #(
    parameter int WAIT_STATES = 2
) (
    input  logic i_Clk,
    input  logic i_arstN,

    dbusIf.slave bus
);
    import dbusPkg::*;

    localparam int CNT_BITS = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
    localparam logic [CNT_BITS-1:0] WAIT_LAST = CNT_BITS'(WAIT_STATES);

    busData_t mem [RAM_DEPTH];

    logic [CNT_BITS-1:0]      waitCnt;
    logic                     access;
    logic                     accessEnd;
    logic [RAM_ADDR_BITS-1:0] index;

    assign access    = bus.read | bus.write;
    assign index     = bus.address[RAM_ADDR_BITS-1:0];
    assign accessEnd = access & ~bus.waitRequest;

    // Stall until the counter reaches the wait state count
    assign bus.waitRequest = access && (waitCnt != WAIT_LAST);

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            waitCnt <= '0;
        end else if (access && bus.waitRequest) begin
            waitCnt <= waitCnt + 1'b1;
        end else begin
            waitCnt <= '0;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (accessEnd && bus.write) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.byteEn[i]) begin
                    mem[index][8*i +: 8] <= bus.writeData[8*i +: 8];
                end
            end
        end
    end

    assign bus.readData = mem[index];

    // Single slave, no arbitration on this link
    assign bus.gnt = 1'b0;

endmodule

//--- hdl/dbusArbiter.sv
module dbusArbiter (
    input  logic  i_Clk,
    input  logic  i_arstN,

    dbusIf.slave  m0,
    dbusIf.slave  m1,
    dbusIf.master ram
);
    import dbusPkg::*;

    arbState_t state;
    arbState_t nextState;

    // Port granted most recently, 1 means port 1
    logic lastGnt;
    logic xferEnd;
    logic owned;
    logic sel1;

    assign xferEnd = (ram.read | ram.write) & ~ram.waitRequest;

    always_comb begin
        nextState = state;
        case (state)
            FREE: begin
                if (m0.req && m1.req) begin
                    nextState = lastGnt ? OWNED0 : OWNED1;
                end else if (m0.req) begin
                    nextState = OWNED0;
                end else if (m1.req) begin
                    nextState = OWNED1;
                end
            end
            // Release at the completing edge so gnt drops with req
            OWNED0: begin
                if (!m0.req || xferEnd) begin
                    nextState = m1.req ? OWNED1 : FREE;
                end
            end
            OWNED1: begin
                if (!m1.req || xferEnd) begin
                    nextState = m0.req ? OWNED0 : FREE;
                end
            end
            default: nextState = FREE;
        endcase
    end

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            state   <= FREE;
            lastGnt <= 1'b1;
        end else begin
            state <= nextState;
            if (nextState == OWNED0) begin
                lastGnt <= 1'b0;
            end else if (nextState == OWNED1) begin
                lastGnt <= 1'b1;
            end
        end
    end

    assign owned = (state != FREE);
    assign sel1  = (state == OWNED1);

    assign m0.gnt = (state == OWNED0);
    assign m1.gnt = (state == OWNED1);

    // Owner to RAM
    assign ram.req       = 1'b0;
    assign ram.address   = sel1 ? m1.address : m0.address;
    assign ram.byteEn    = sel1 ? m1.byteEn : m0.byteEn;
    assign ram.writeData = sel1 ? m1.writeData : m0.writeData;
    assign ram.read      = owned & (sel1 ? m1.read : m0.read);
    assign ram.write     = owned & (sel1 ? m1.write : m0.write);

    // RAM back to owner, the other port is held off
    assign m0.readData    = (state == OWNED0) ? ram.readData : '0;
    assign m1.readData    = sel1 ? ram.readData : '0;
    assign m0.waitRequest = (state == OWNED0) ? ram.waitRequest : 1'b1;
    assign m1.waitRequest = sel1 ? ram.waitRequest : 1'b1;

endmodule

//--- hdl/dbusMaster.sv
module dbusMaster (
    input  logic               i_Clk,
    input  logic               i_arstN,

    input  logic               i_cpuRe,
    input  logic               i_cpuWe,
    input  dbusPkg::busMode_t  i_cpuMode,
    input  dbusPkg::cpuAddr_t  i_cpuAddr,
    input  dbusPkg::busData_t  i_cpuWd,
    output dbusPkg::busData_t  o_cpuRd,
    output logic               o_cpuBusy,
    output logic               o_cpuDone,
    output logic               o_cpuMisaligned,

    dbusIf.master              bus
);
    import dbusPkg::*;

    masterState_t state;
    masterState_t nextState;

    busMode_t modeQ;
    cpuAddr_t addrQ;
    busData_t wdQ;
    logic     isWriteQ;
    busData_t rdQ;
    logic     misalignedQ;

    logic     accept;
    logic     misaligned;
    logic     start;
    logic     xferDone;
    logic     [7:0] laneByte;
    logic     [15:0] laneHalf;
    busData_t rdFmt;

    assign accept = (i_cpuRe | i_cpuWe) & ~o_cpuBusy;

    // Halfword needs bit 0 clear, word needs bits 1:0 clear
    assign misaligned = (i_cpuMode[1:0] == 2'b01 && i_cpuAddr[0]) ||
                        (i_cpuMode[1] && i_cpuAddr[1:0] != 2'b00);
    assign start    = accept & ~misaligned;
    assign xferDone = (state == ACCESS) & bus.gnt & ~bus.waitRequest;

    always_comb begin
        nextState = state;
        case (state)
            IDLE:    if (start) nextState = REQUEST;
            REQUEST: if (bus.gnt) nextState = ACCESS;
            ACCESS:  if (xferDone) nextState = DONE;
            DONE:    nextState = start ? REQUEST : IDLE;
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            state       <= IDLE;
            misalignedQ <= 1'b0;
        end else begin
            state       <= nextState;
            misalignedQ <= accept & misaligned;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (accept) begin
            modeQ    <= i_cpuMode;
            addrQ    <= i_cpuAddr;
            wdQ      <= i_cpuWd;
            isWriteQ <= i_cpuWe & ~i_cpuRe;
        end
        if (xferDone && !isWriteQ) begin
            rdQ <= rdFmt;
        end
    end

    // Lane select and write data replication
    always_comb begin
        case (modeQ[1:0])
            2'b00: begin
                bus.byteEn    = 4'b0001 << addrQ[1:0];
                bus.writeData = {4{wdQ[7:0]}};
            end
            2'b01: begin
                bus.byteEn    = addrQ[1] ? 4'b1100 : 4'b0011;
                bus.writeData = {2{wdQ[15:0]}};
            end
            default: begin
                bus.byteEn    = 4'b1111;
                bus.writeData = wdQ;
            end
        endcase
    end

    assign laneByte = bus.readData[{addrQ[1:0], 3'b000} +: 8];
    assign laneHalf = addrQ[1] ? bus.readData[31:16] : bus.readData[15:0];

    always_comb begin
        case (modeQ)
            MODE_B:  rdFmt = {{24{laneByte[7]}}, laneByte};
            MODE_BU: rdFmt = {24'b0, laneByte};
            MODE_H:  rdFmt = {{16{laneHalf[15]}}, laneHalf};
            MODE_HU: rdFmt = {16'b0, laneHalf};
            default: rdFmt = bus.readData;
        endcase
    end

    assign bus.req     = o_cpuBusy;
    assign bus.address = addrQ[31:2];
    assign bus.read    = (state == ACCESS) & bus.gnt & ~isWriteQ;
    assign bus.write   = (state == ACCESS) & bus.gnt & isWriteQ;

    assign o_cpuBusy       = (state == REQUEST) || (state == ACCESS);
    assign o_cpuDone       = (state == DONE);
    assign o_cpuRd         = rdQ;
    assign o_cpuMisaligned = misalignedQ;

endmodule

//--- hdl/dbusIf.sv
interface dbusIf;
    import dbusPkg::*;

    logic     req;
    logic     gnt;
    busAddr_t address;
    byteEn_t  byteEn;
    logic     read;
    logic     write;
    busData_t writeData;
    busData_t readData;
    logic     waitRequest;

    modport master (
        output req, address, byteEn, read, write, writeData,
        input  gnt, readData, waitRequest
    );

    modport slave (
        input  req, address, byteEn, read, write, writeData,
        output gnt, readData, waitRequest
    );

endinterface

//--- hdl/dbusPkg.sv
package dbusPkg;

    // Core side byte address
    typedef logic [31:0] cpuAddr_t;

    // Word address on the bus
    typedef logic [29:0] busAddr_t;

    typedef logic [31:0] busData_t;
    typedef logic [3:0]  byteEn_t;

    // Access mode, RISC-V funct3 of loads and stores
    typedef logic [2:0]  busMode_t;

    localparam busMode_t MODE_B  = 3'd0;
    localparam busMode_t MODE_H  = 3'd1;
    localparam busMode_t MODE_W  = 3'd2;
    localparam busMode_t MODE_BU = 3'd4;
    localparam busMode_t MODE_HU = 3'd5;

    localparam int RAM_DEPTH     = 64;
    localparam int RAM_ADDR_BITS = 6;

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        ACCESS,
        DONE
    } masterState_t;

    // Bus ownership
    typedef enum logic [1:0] {
        FREE,
        OWNED0,
        OWNED1
    } arbState_t;

endpackage
